// ==== alu_unit.sv ====
`include "exec_defines.svh"

module alu_unit (
    input  logic [`XLEN-1:0]   opa,
    input  logic [`XLEN-1:0]   opb,
    input  exec_pkg::alu_func_e func,
    output logic [`XLEN-1:0]   result
);

    import exec_pkg::*;

    logic [4:0] shamt;
    logic       lt_signed;
    logic       lt_unsigned;

    assign shamt       = opb[4:0];
    assign lt_signed   = $signed(opa) < $signed(opb);
    assign lt_unsigned = opa < opb;

    always_comb begin
        case (func)
            ALU_ADD:  result = opa + opb;
            ALU_SUB:  result = opa - opb;
            // Compare results are a single bit, zero extended
            ALU_SLT:  result = {{(`XLEN-1){1'b0}}, lt_signed};
            ALU_SLTU: result = {{(`XLEN-1){1'b0}}, lt_unsigned};
            ALU_AND:  result = opa & opb;
            ALU_OR:   result = opa | opb;
            ALU_XOR:  result = opa ^ opb;
            ALU_SLL:  result = opa << shamt;
            ALU_SRL:  result = opa >> shamt;
            ALU_SRA:  result = $signed(opa) >>> shamt;
            default:  result = '0;
        endcase
    end

endmodule

// ==== branch_unit.sv ====
`include "exec_defines.svh"

module branch_unit (
    input  logic [`XLEN-1:0]      rs1,
    input  logic [`XLEN-1:0]      rs2,
    input  exec_pkg::branch_func_e func,
    input  logic [`XLEN-1:0]      pc,
    input  logic [`XLEN-1:0]      imm,
    output logic                  take,
    output logic [`XLEN-1:0]      target
);

    import exec_pkg::*;

    logic [`XLEN-1:0] jalr_sum;

    always_comb begin
        case (func)
            BR_BEQ:  take = rs1 == rs2;
            BR_BNE:  take = rs1 != rs2;
            BR_BLT:  take = $signed(rs1) < $signed(rs2);
            BR_BGE:  take = $signed(rs1) >= $signed(rs2);
            BR_BLTU: take = rs1 < rs2;
            BR_BGEU: take = rs1 >= rs2;
            // Jumps always redirect
            default: take = 1'b1;
        endcase
    end

    // JALR target is register relative with the low bit dropped
    assign jalr_sum = rs1 + imm;
    assign target   = (func == BR_JALR) ? {jalr_sum[`XLEN-1:1], 1'b0} : pc + imm;

endmodule

// ==== complete_stage.sv ====
`include "exec_defines.svh"

module complete_stage (
    input  logic                    clock,
    input  logic                    reset,
    input  logic                    mispredict,
    input  exec_pkg::exec_pkt_t     exec,
    output exec_pkg::cdb_entry_t    cdb_out,
    output exec_pkg::complete_pkt_t comp
);

    import exec_pkg::*;

    cdb_entry_t    cdb_next;
    complete_pkt_t comp_next;

    // ==========================================================
    // CDB broadcast and ROB completion
    // ==========================================================
    always_comb begin
        // Plain branches write no register
        cdb_next.valid = exec.valid && exec.dest_tag != '0 &&
                         (!exec.branch_valid || exec.link);
        cdb_next.tag   = exec.dest_tag;
        cdb_next.data  = exec.result;

        comp_next.valid        = exec.valid;
        comp_next.rob_idx      = exec.rob_idx;
        comp_next.dest_tag     = exec.dest_tag;
        comp_next.branch_valid = exec.branch_valid;
        comp_next.taken        = exec.taken;
        comp_next.target       = exec.target;
        comp_next.result       = exec.result;
    end

    always_ff @(posedge clock) begin
        cdb_out <= cdb_next;
        comp    <= comp_next;
        if (reset || mispredict) begin
            cdb_out.valid <= 1'b0;
            comp.valid    <= 1'b0;
        end
    end

endmodule

// ==== exec_checker.sv ====
`include "exec_defines.svh"

module exec_checker (
    input  logic                                  clock,
    input  logic                                  reset,
    input  logic                                  mispredict,
    input  exec_pkg::issue_pkt_t                  issue,
    input  exec_pkg::cdb_entry_t [`CDB_WIDTH-1:0] cdb_in,
    input  exec_pkg::prf_req_t                    prf_req,
    input  logic [`XLEN-1:0]                      prf_data1,
    input  logic [`XLEN-1:0]                      prf_data2,
    input  exec_pkg::cdb_entry_t                  cdb_out,
    input  exec_pkg::complete_pkt_t               comp,
    output int                                    value_errors,
    output int                                    pulse_errors,
    output int                                    req_errors,
    output int                                    cycles_checked
);

    import exec_pkg::*;

    // Model pipeline with the output stage at index 2
    complete_pkt_t exp_comp [3];
    cdb_entry_t    exp_cdb  [3];

    function automatic bit value_ok(input string name, input logic [31:0] exp_val,
                                    input logic [31:0] act_val);
        if (act_val !== exp_val) begin
            $display("[FAIL] %s expected %h actual %h at %0t", name, exp_val, act_val, $time);
            return 1'b0;
        end
        return 1'b1;
    endfunction

    function automatic logic [`XLEN-1:0] alu_model(input logic [`XLEN-1:0] a,
                                                   input logic [`XLEN-1:0] b,
                                                   input alu_func_e f);
        case (f)
            ALU_ADD:  return a + b;
            ALU_SUB:  return a - b;
            ALU_SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            ALU_SLTU: return (a < b) ? 32'd1 : 32'd0;
            ALU_AND:  return a & b;
            ALU_OR:   return a | b;
            ALU_XOR:  return a ^ b;
            ALU_SLL:  return a << b[4:0];
            ALU_SRL:  return a >> b[4:0];
            ALU_SRA:  return $signed(a) >>> b[4:0];
            default:  return '0;
        endcase
    endfunction

    function automatic logic branch_taken(input logic [`XLEN-1:0] a,
                                          input logic [`XLEN-1:0] b,
                                          input branch_func_e f);
        case (f)
            BR_BEQ:  return a == b;
            BR_BNE:  return a != b;
            BR_BLT:  return $signed(a) < $signed(b);
            BR_BGE:  return !($signed(a) < $signed(b));
            BR_BLTU: return a < b;
            BR_BGEU: return !(a < b);
            default: return 1'b1;
        endcase
    endfunction

    // ==========================================================
    // Expected values from the inputs at each rising edge
    // ==========================================================
    always @(posedge clock) begin
        logic [`XLEN-1:0] rs1;
        logic [`XLEN-1:0] rs2;
        logic [`XLEN-1:0] opa;
        logic [`XLEN-1:0] opb;
        logic [`XLEN-1:0] npc;
        logic             want_en2;
        complete_pkt_t    c_new;
        cdb_entry_t       b_new;
        want_en2 = issue.valid && (issue.kind == FU_BRANCH || issue.opb_sel == OPB_RS2);
        if (!value_ok("prf_req.en1", 32'(issue.valid), 32'(prf_req.en1))) req_errors++;
        if (!value_ok("prf_req.en2", 32'(want_en2), 32'(prf_req.en2))) req_errors++;
        if (issue.valid) begin
            if (!value_ok("prf_req.tag1", 32'(issue.src1_tag), 32'(prf_req.tag1))) req_errors++;
            if (!value_ok("prf_req.tag2", 32'(issue.src2_tag), 32'(prf_req.tag2))) req_errors++;
        end

        // CDB data beats the register file and the last entry wins
        rs1 = prf_data1;
        rs2 = prf_data2;
        for (int c = 0; c < `CDB_WIDTH; c++) begin
            if (cdb_in[c].valid && cdb_in[c].tag == issue.src1_tag) rs1 = cdb_in[c].data;
            if (cdb_in[c].valid && cdb_in[c].tag == issue.src2_tag) rs2 = cdb_in[c].data;
        end
        npc = issue.pc + `PC_STEP;
        case (issue.opa_sel)
            OPA_RS1: opa = rs1;
            OPA_NPC: opa = npc;
            OPA_PC:  opa = issue.pc;
            default: opa = '0;
        endcase
        opb = (issue.opb_sel == OPB_IMM) ? issue.imm : rs2;

        c_new.valid        = issue.valid;
        c_new.rob_idx      = issue.rob_idx;
        c_new.dest_tag     = issue.dest_tag;
        c_new.branch_valid = issue.kind == FU_BRANCH;
        if (issue.kind == FU_BRANCH) begin
            c_new.taken  = branch_taken(rs1, rs2, issue.br_func);
            c_new.target = (issue.br_func == BR_JALR) ? ((rs1 + issue.imm) & ~32'd1)
                                                      : issue.pc + issue.imm;
            c_new.result = npc;
        end else begin
            c_new.taken  = 1'b0;
            c_new.target = '0;
            c_new.result = alu_model(opa, opb, issue.alu_func);
        end
        b_new.valid = issue.valid && issue.dest_tag != 0 && (issue.kind == FU_ALU ||
                      issue.br_func == BR_JAL || issue.br_func == BR_JALR);
        b_new.tag   = issue.dest_tag;
        b_new.data  = c_new.result;

        exp_comp[2] = exp_comp[1];
        exp_comp[1] = exp_comp[0];
        exp_comp[0] = c_new;
        exp_cdb[2]  = exp_cdb[1];
        exp_cdb[1]  = exp_cdb[0];
        exp_cdb[0]  = b_new;
        // Flush drops everything including the new issue
        if (reset || mispredict) begin
            for (int s = 0; s < 3; s++) begin
                exp_comp[s].valid = 1'b0;
                exp_cdb[s].valid  = 1'b0;
            end
        end
    end

    // ==========================================================
    // Output compare at mid cycle
    // ==========================================================
    always @(negedge clock) begin
        cycles_checked++;
        if (comp.valid !== exp_comp[2].valid) begin
            pulse_errors++;
            if (exp_comp[2].valid) begin
                $display("Completion for ROB index %0d did not appear at %0t",
                         exp_comp[2].rob_idx, $time);
            end else begin
                $display("Completion pulse appeared with none expected at %0t", $time);
            end
        end else if (exp_comp[2].valid) begin
            if (!value_ok("comp.rob_idx", 32'(exp_comp[2].rob_idx), 32'(comp.rob_idx)))
                value_errors++;
            if (!value_ok("comp.dest_tag", 32'(exp_comp[2].dest_tag), 32'(comp.dest_tag)))
                value_errors++;
            if (!value_ok("comp.branch_valid", 32'(exp_comp[2].branch_valid),
                          32'(comp.branch_valid)))
                value_errors++;
            if (!value_ok("comp.taken", 32'(exp_comp[2].taken), 32'(comp.taken)))
                value_errors++;
            if (!value_ok("comp.target", exp_comp[2].target, comp.target)) value_errors++;
            if (!value_ok("comp.result", exp_comp[2].result, comp.result)) value_errors++;
        end

        if (cdb_out.valid !== exp_cdb[2].valid) begin
            pulse_errors++;
            if (exp_cdb[2].valid) begin
                $display("CDB broadcast for tag %0d did not appear at %0t",
                         exp_cdb[2].tag, $time);
            end else begin
                $display("CDB broadcast appeared with none expected at %0t", $time);
            end
        end else if (exp_cdb[2].valid) begin
            if (!value_ok("cdb_out.tag", 32'(exp_cdb[2].tag), 32'(cdb_out.tag)))
                value_errors++;
            if (!value_ok("cdb_out.data", exp_cdb[2].data, cdb_out.data)) value_errors++;
        end
    end

endmodule

// ==== exec_defines.svh ====
`ifndef EXEC_DEFINES_SVH
`define EXEC_DEFINES_SVH

// ==========================================================
// Execute path widths
// ==========================================================

// Data and address width
`define XLEN 32

// Physical register tag, zero means no destination
`define TAG_W 6

// Reorder buffer index
`define ROB_IDX_W 5

// Incoming CDB entries checked for forwarding
`define CDB_WIDTH 2

// Instruction size in bytes
`define PC_STEP 4

`endif

// ==== exec_pipeline.sv ====
`include "exec_defines.svh"

module exec_pipeline (
    input  logic                                  clock,
    input  logic                                  reset,
    input  logic                                  mispredict,
    input  exec_pkg::issue_pkt_t                  issue,
    input  exec_pkg::cdb_entry_t [`CDB_WIDTH-1:0] cdb_in,
    output exec_pkg::prf_req_t                    prf_req,
    input  logic [`XLEN-1:0]                      prf_data1,
    input  logic [`XLEN-1:0]                      prf_data2,
    output exec_pkg::cdb_entry_t                  cdb_out,
    output exec_pkg::complete_pkt_t               comp
);

    import exec_pkg::*;

    opnd_pkt_t opnd;
    exec_pkt_t exec;

    // Operand read, registered at the first edge
    operand_stage operand_stage_i (
        .clock      (clock),
        .reset      (reset),
        .mispredict (mispredict),
        .issue      (issue),
        .cdb_in     (cdb_in),
        .prf_req    (prf_req),
        .prf_data1  (prf_data1),
        .prf_data2  (prf_data2),
        .opnd       (opnd)
    );

    execute_stage execute_stage_i (
        .clock      (clock),
        .reset      (reset),
        .mispredict (mispredict),
        .opnd       (opnd),
        .exec       (exec)
    );

    complete_stage complete_stage_i (
        .clock      (clock),
        .reset      (reset),
        .mispredict (mispredict),
        .exec       (exec),
        .cdb_out    (cdb_out),
        .comp       (comp)
    );

endmodule

// ==== exec_pkg.sv ====
`include "exec_defines.svh"

package exec_pkg;

    // ==========================================================
    // Opcodes and operand selects
    // ==========================================================
    typedef enum logic {
        FU_ALU    = 1'b0,
        FU_BRANCH = 1'b1
    } fu_kind_e;

    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_SLT  = 4'd2,
        ALU_SLTU = 4'd3,
        ALU_AND  = 4'd4,
        ALU_OR   = 4'd5,
        ALU_XOR  = 4'd6,
        ALU_SLL  = 4'd7,
        ALU_SRL  = 4'd8,
        ALU_SRA  = 4'd9
    } alu_func_e;

    typedef enum logic [2:0] {
        BR_BEQ  = 3'd0,
        BR_BNE  = 3'd1,
        BR_BLT  = 3'd2,
        BR_BGE  = 3'd3,
        BR_BLTU = 3'd4,
        BR_BGEU = 3'd5,
        BR_JAL  = 3'd6,
        BR_JALR = 3'd7
    } branch_func_e;

    typedef enum logic [1:0] {
        OPA_RS1  = 2'd0,
        OPA_NPC  = 2'd1,
        OPA_PC   = 2'd2,
        OPA_ZERO = 2'd3
    } opa_sel_e;

    typedef enum logic {
        OPB_RS2 = 1'b0,
        OPB_IMM = 1'b1
    } opb_sel_e;

    // ==========================================================
    // Stage packets
    // ==========================================================
    typedef struct packed {
        logic                  valid;
        fu_kind_e              kind;
        alu_func_e             alu_func;
        branch_func_e          br_func;
        opa_sel_e              opa_sel;
        opb_sel_e              opb_sel;
        logic [`XLEN-1:0]      pc;
        logic [`XLEN-1:0]      imm;
        logic [`TAG_W-1:0]     src1_tag;
        logic [`TAG_W-1:0]     src2_tag;
        logic [`TAG_W-1:0]     dest_tag;
        logic [`ROB_IDX_W-1:0] rob_idx;
    } issue_pkt_t;

    typedef struct packed {
        logic              en1;
        logic              en2;
        logic [`TAG_W-1:0] tag1;
        logic [`TAG_W-1:0] tag2;
    } prf_req_t;

    typedef struct packed {
        logic              valid;
        logic [`TAG_W-1:0] tag;
        logic [`XLEN-1:0]  data;
    } cdb_entry_t;

    // Issue fields with source tags replaced by resolved values
    typedef struct packed {
        logic                  valid;
        fu_kind_e              kind;
        alu_func_e             alu_func;
        branch_func_e          br_func;
        opa_sel_e              opa_sel;
        opb_sel_e              opb_sel;
        logic [`XLEN-1:0]      pc;
        logic [`XLEN-1:0]      imm;
        logic [`TAG_W-1:0]     dest_tag;
        logic [`ROB_IDX_W-1:0] rob_idx;
        logic [`XLEN-1:0]      rs1;
        logic [`XLEN-1:0]      rs2;
    } opnd_pkt_t;

    typedef struct packed {
        logic                  valid;
        logic [`ROB_IDX_W-1:0] rob_idx;
        logic [`TAG_W-1:0]     dest_tag;
        logic                  branch_valid;
        logic                  taken;
        logic [`XLEN-1:0]      target;
        logic [`XLEN-1:0]      result;
        logic                  link;      // JAL or JALR
    } exec_pkt_t;

    typedef struct packed {
        logic                  valid;
        logic [`ROB_IDX_W-1:0] rob_idx;
        logic [`TAG_W-1:0]     dest_tag;
        logic                  branch_valid;
        logic                  taken;
        logic [`XLEN-1:0]      target;
        logic [`XLEN-1:0]      result;
    } complete_pkt_t;

endpackage

// ==== execute_stage.sv ====
`include "exec_defines.svh"

module execute_stage (
    input  logic                clock,
    input  logic                reset,
    input  logic                mispredict,
    input  exec_pkg::opnd_pkt_t opnd,
    output exec_pkg::exec_pkt_t exec
);

    import exec_pkg::*;

    logic [`XLEN-1:0] npc;
    logic [`XLEN-1:0] opa;
    logic [`XLEN-1:0] opb;
    logic [`XLEN-1:0] alu_result;
    logic             br_take;
    logic [`XLEN-1:0] br_target;
    logic             is_branch;
    exec_pkt_t        exec_next;

    assign npc       = opnd.pc + `XLEN'(`PC_STEP);
    assign is_branch = opnd.kind == FU_BRANCH;

    // ==========================================================
    // Operand select
    // ==========================================================
    always_comb begin
        case (opnd.opa_sel)
            OPA_RS1: opa = opnd.rs1;
            OPA_NPC: opa = npc;
            OPA_PC:  opa = opnd.pc;
            default: opa = '0;
        endcase
        opb = (opnd.opb_sel == OPB_RS2) ? opnd.rs2 : opnd.imm;
    end

    alu_unit alu_unit_i (
        .opa    (opa),
        .opb    (opb),
        .func   (opnd.alu_func),
        .result (alu_result)
    );

    // Branches compare the raw register values
    branch_unit branch_unit_i (
        .rs1    (opnd.rs1),
        .rs2    (opnd.rs2),
        .func   (opnd.br_func),
        .pc     (opnd.pc),
        .imm    (opnd.imm),
        .take   (br_take),
        .target (br_target)
    );

    // ==========================================================
    // Execute register
    // ==========================================================
    always_comb begin
        exec_next.valid        = opnd.valid;
        exec_next.rob_idx      = opnd.rob_idx;
        exec_next.dest_tag     = opnd.dest_tag;
        exec_next.branch_valid = is_branch;
        exec_next.taken        = is_branch && br_take;
        exec_next.target       = is_branch ? br_target : '0;
        // Link value doubles as the branch result
        exec_next.result       = is_branch ? npc : alu_result;
        exec_next.link         = is_branch &&
                                 (opnd.br_func == BR_JAL || opnd.br_func == BR_JALR);
    end

    always_ff @(posedge clock) begin
        exec <= exec_next;
        if (reset || mispredict) begin
            exec.valid <= 1'b0;
        end
    end

    alu_func_legal_a: assert property (@(posedge clock) disable iff (reset)
        (opnd.valid && opnd.kind == FU_ALU) |->
        opnd.alu_func inside {ALU_ADD, ALU_SUB, ALU_SLT, ALU_SLTU, ALU_AND,
                              ALU_OR, ALU_XOR, ALU_SLL, ALU_SRL, ALU_SRA});

endmodule

// ==== operand_stage.sv ====
`include "exec_defines.svh"

module operand_stage (
    input  logic                                  clock,
    input  logic                                  reset,
    input  logic                                  mispredict,
    input  exec_pkg::issue_pkt_t                  issue,
    input  exec_pkg::cdb_entry_t [`CDB_WIDTH-1:0] cdb_in,
    output exec_pkg::prf_req_t                    prf_req,
    input  logic [`XLEN-1:0]                      prf_data1,
    input  logic [`XLEN-1:0]                      prf_data2,
    output exec_pkg::opnd_pkt_t                   opnd
);

    import exec_pkg::*;

    logic [`XLEN-1:0] rs1_val;
    logic [`XLEN-1:0] rs2_val;
    opnd_pkt_t        opnd_next;
    logic             cdb_dup_tag;

    // ==========================================================
    // PRF read request
    // ==========================================================
    always_comb begin
        prf_req.en1  = issue.valid;
        // Second port only when rs2 is really consumed
        prf_req.en2  = issue.valid &&
                       (issue.kind == FU_BRANCH || issue.opb_sel == OPB_RS2);
        prf_req.tag1 = issue.src1_tag;
        prf_req.tag2 = issue.src2_tag;
    end

    // ==========================================================
    // CDB forwarding
    // ==========================================================
    always_comb begin
        rs1_val = prf_data1;
        rs2_val = prf_data2;
        // Later entries override earlier ones
        for (int c = 0; c < `CDB_WIDTH; c++) begin
            if (cdb_in[c].valid && cdb_in[c].tag == issue.src1_tag) begin
                rs1_val = cdb_in[c].data;
            end
            if (cdb_in[c].valid && cdb_in[c].tag == issue.src2_tag) begin
                rs2_val = cdb_in[c].data;
            end
        end
    end

    always_comb begin
        opnd_next.valid    = issue.valid;
        opnd_next.kind     = issue.kind;
        opnd_next.alu_func = issue.alu_func;
        opnd_next.br_func  = issue.br_func;
        opnd_next.opa_sel  = issue.opa_sel;
        opnd_next.opb_sel  = issue.opb_sel;
        opnd_next.pc       = issue.pc;
        opnd_next.imm      = issue.imm;
        opnd_next.dest_tag = issue.dest_tag;
        opnd_next.rob_idx  = issue.rob_idx;
        opnd_next.rs1      = rs1_val;
        opnd_next.rs2      = rs2_val;
    end

    always_ff @(posedge clock) begin
        opnd <= opnd_next;
        if (reset || mispredict) begin
            opnd.valid <= 1'b0;
        end
    end

    always_comb begin
        cdb_dup_tag = 1'b0;
        for (int i = 0; i < `CDB_WIDTH; i++) begin
            for (int j = i + 1; j < `CDB_WIDTH; j++) begin
                if (cdb_in[i].valid && cdb_in[j].valid && cdb_in[i].tag == cdb_in[j].tag) begin
                    cdb_dup_tag = 1'b1;
                end
            end
        end
    end

    // A physical tag is written back by one producer at a time
    cdb_unique_tag_a: assert property (@(posedge clock) disable iff (reset) !cdb_dup_tag);

endmodule

// ==== tb_exec_pipeline.sv ====
`include "exec_defines.svh"

module tb_exec_pipeline;

    import exec_pkg::*;

    localparam int RESET_CYCLES = 16;
    localparam int NUM_TRANS    = 2000;
    localparam int CLOCK_PERIOD = 4;

    logic                        clock;
    logic                        reset;
    logic                        mispredict;
    issue_pkt_t                  issue;
    cdb_entry_t [`CDB_WIDTH-1:0] cdb_in;
    prf_req_t                    prf_req;
    logic [`XLEN-1:0]            prf_data1;
    logic [`XLEN-1:0]            prf_data2;
    cdb_entry_t                  cdb_out;
    complete_pkt_t               comp;
    int                          value_errors;
    int                          pulse_errors;
    int                          req_errors;
    int                          cycles_checked;
    logic [31:0]                 lcg_state;

    initial clock = 1'b0;
    always #(CLOCK_PERIOD / 2) clock = ~clock;

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // Register file contents are a fixed hash of the tag
    function automatic logic [`XLEN-1:0] prf_value(input logic [`TAG_W-1:0] tag);
        return (32'h9e3779b9 * {26'b0, tag}) ^ {tag, tag, tag, tag, tag, 2'b11};
    endfunction

    assign prf_data1 = prf_req.en1 ? prf_value(prf_req.tag1) : '0;
    assign prf_data2 = prf_req.en2 ? prf_value(prf_req.tag2) : '0;

    exec_pipeline exec_pipeline_i (
        .clock      (clock),
        .reset      (reset),
        .mispredict (mispredict),
        .issue      (issue),
        .cdb_in     (cdb_in),
        .prf_req    (prf_req),
        .prf_data1  (prf_data1),
        .prf_data2  (prf_data2),
        .cdb_out    (cdb_out),
        .comp       (comp)
    );

    exec_checker exec_checker_i (
        .clock          (clock),
        .reset          (reset),
        .mispredict     (mispredict),
        .issue          (issue),
        .cdb_in         (cdb_in),
        .prf_req        (prf_req),
        .prf_data1      (prf_data1),
        .prf_data2      (prf_data2),
        .cdb_out        (cdb_out),
        .comp           (comp),
        .value_errors   (value_errors),
        .pulse_errors   (pulse_errors),
        .req_errors     (req_errors),
        .cycles_checked (cycles_checked)
    );

    task automatic drive_idle();
        issue      = '0;
        cdb_in     = '0;
        mispredict = 1'b0;
    endtask

    // ==========================================================
    // Random instruction and CDB traffic
    // ==========================================================
    task automatic drive_random();
        logic [31:0] r;
        r = next_rand();
        issue.valid    = r[31:30] != 2'b00;
        issue.kind     = fu_kind_e'(r[29]);
        issue.opa_sel  = opa_sel_e'(r[28:27]);
        issue.opb_sel  = opb_sel_e'(r[26]);
        issue.br_func  = branch_func_e'(r[25:23]);
        issue.rob_idx  = r[22:18];
        issue.alu_func = alu_func_e'(4'(r[17:10] % 10));
        r = next_rand();
        // Small source tag range so forwarding and equal operands happen often
        issue.src1_tag = {2'b00, r[31:28]};
        issue.src2_tag = {2'b00, r[27:24]};
        issue.dest_tag = (r[23:21] == 3'b000) ? '0 : r[20:15];
        r = next_rand();
        issue.pc = {r[31:2], 2'b00};
        r = next_rand();
        issue.imm = r[31] ? {{20{r[30]}}, r[30:19]} : r;
        for (int c = 0; c < `CDB_WIDTH; c++) begin
            r = next_rand();
            cdb_in[c].valid = r[31];
            cdb_in[c].tag   = {2'b00, r[30:27]};
            cdb_in[c].data  = next_rand();
        end
        if (cdb_in[0].valid && cdb_in[1].valid && cdb_in[0].tag == cdb_in[1].tag) begin
            cdb_in[1].tag = cdb_in[1].tag ^ 6'h10;
        end
        r = next_rand();
        mispredict = (r[31:16] % 40) == 0;
    endtask

    initial begin
        lcg_state = 32'h180e9f0b;
        reset     = 1'b1;
        drive_idle();
        repeat (RESET_CYCLES) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;
        repeat (NUM_TRANS) begin
            drive_random();
            @(negedge clock);
        end
        // Drain the three stages
        drive_idle();
        repeat (5) @(negedge clock);
        $display("Errors: value %0d, pulse %0d, read request %0d over %0d cycles",
                 value_errors, pulse_errors, req_errors, cycles_checked);
        if (value_errors + pulse_errors + req_errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

    initial begin
        #((RESET_CYCLES + NUM_TRANS + 10) * CLOCK_PERIOD);
        $display("Timeout at %0t, stimulus did not complete", $time);
        $display("Test FAILED");
        $finish;
    end

endmodule

// ==== verilog.f ====
+incdir+.
exec_pkg.sv
alu_unit.sv
branch_unit.sv
operand_stage.sv
execute_stage.sv
complete_stage.sv
exec_pipeline.sv
exec_checker.sv
tb_exec_pipeline.sv
